// ==== common/soc_pkg.sv ====
`default_nettype none

package soc_pkg;

    // bus widths
    typedef logic [31:0] bus_addr_t;
    typedef logic [7:0]  bus_data_t;

    typedef logic [15:0] lfsr_state_t;
    typedef logic [15:0] timer_count_t;

    // address map, ROM window 0xFFFFF000 to 0xFFFFF7FF
    localparam logic [20:0] ROM_PREFIX = 21'h1FFFFE;
    localparam logic [23:0] TIMER_PAGE = 24'hFFFFFD;
    localparam logic [23:0] PRNG_PAGE  = 24'hFFFFFE;
    localparam logic [23:0] LED_PAGE   = 24'hFFFFFF;

    // memory sizes
    localparam int ROM_ADDR_BITS = 6;
    localparam int ROM_BYTES     = 2 ** ROM_ADDR_BITS;
    localparam int RAM_ADDR_BITS = 13;
    localparam int RAM_BYTES     = 2 ** RAM_ADDR_BITS;

    // random generator
    localparam lfsr_state_t LFSR_TAPS         = 16'hB400;
    localparam lfsr_state_t LFSR_DEFAULT_SEED = 16'hACE1;

    // timer register offsets
    localparam logic [2:0] TMR_RELOAD_LO = 3'd0;
    localparam logic [2:0] TMR_RELOAD_HI = 3'd1;
    localparam logic [2:0] TMR_CTRL      = 3'd2;
    localparam logic [2:0] TMR_STATUS    = 3'd3;
    localparam logic [2:0] TMR_COUNT_LO  = 3'd4;
    localparam logic [2:0] TMR_COUNT_HI  = 3'd5;

    // led register offsets
    localparam logic [1:0] LED_VALUE  = 2'd0;
    localparam logic [1:0] LED_SET    = 2'd1;
    localparam logic [1:0] LED_CLEAR  = 2'd2;
    localparam logic [1:0] LED_TOGGLE = 2'd3;

    // generator register offsets
    localparam logic PRNG_LO = 1'b0;
    localparam logic PRNG_HI = 1'b1;

endpackage

`default_nettype wire

// ==== common/wb8_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface wb8_if
    import soc_pkg::*;
();

    logic      stb;
    logic      we;
    bus_addr_t adr;
    bus_data_t dat_w;
    bus_data_t dat_r;
    // one-cycle pulse from the slave
    logic      ack;

    modport master (
        output stb,
        output we,
        output adr,
        output dat_w,
        input  dat_r,
        input  ack
    );

    modport slave (
        input  stb,
        input  we,
        input  adr,
        input  dat_w,
        output dat_r,
        output ack
    );

endinterface

`default_nettype wire

// ==== memory/boot_rom.hex ====
3C 61 86 AB D0 F5 1A 3F
64 89 AE D3 F8 1D 42 67
8C B1 D6 FB 20 45 6A 8F
B4 D9 FE 23 48 6D 92 B7
DC 01 26 4B 70 95 BA DF
04 29 4E 73 98 BD E2 07
2C 51 76 9B C0 E5 0A 2F
54 79 9E C3 E8 0D 32 57

// ==== memory/boot_rom.sv ====
`timescale 1ns/1ns
`default_nettype none

module boot_rom
    import soc_pkg::*;
(
    input wire logic clk,
    input wire logic arst_n_i,
    wb8_if.slave     bus
);

    bus_data_t rom_mem [0:ROM_BYTES-1];
    logic      access;

    initial begin
        $readmemh("memory/boot_rom.hex", rom_mem);
    end

    // new access only when not already acking
    assign access = bus.stb & ~bus.ack;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= access;
        end
    end

    // low address bits only, so the window mirrors
    // writes are acked but never stored
    always_ff @(posedge clk) begin
        if (access) begin
            bus.dat_r <= rom_mem[bus.adr[ROM_ADDR_BITS-1:0]];
        end
    end

endmodule

`default_nettype wire

// ==== memory/data_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module data_ram
    import soc_pkg::*;
(
    input wire logic clk,
    input wire logic arst_n_i,
    wb8_if.slave     bus
);

    bus_data_t ram_mem [0:RAM_BYTES-1];
    logic      access;
    logic [RAM_ADDR_BITS-1:0] ram_addr;

    assign access   = bus.stb & ~bus.ack;
    assign ram_addr = bus.adr[RAM_ADDR_BITS-1:0];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= access;
        end
    end

    // write lands on the same edge that raises ack
    always_ff @(posedge clk) begin
        if (access) begin
            if (bus.we) begin
                ram_mem[ram_addr] <= bus.dat_w;
            end
            bus.dat_r <= ram_mem[ram_addr];
        end
    end

endmodule

`default_nettype wire

// ==== soc_bus_top.f ====
common/soc_pkg.sv
common/wb8_if.sv
source/bus_decoder.sv
memory/boot_rom.sv
memory/data_ram.sv
source/led_port.sv
timer/interval_timer.sv
source/prng_lfsr.sv
source/soc_bus_top.sv
verification/soc_bus_properties.sv
verification/soc_bus_tb.sv

// ==== source/bus_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module bus_decoder
    import soc_pkg::*;
(
    input  wire logic      bus_stb_i,
    input  wire bus_addr_t bus_adr_i,
    input  wire bus_data_t bus_dat_i,
    input  wire logic      bus_we_i,
    output bus_data_t      bus_dat_o,
    output logic           bus_ack_o,
    wb8_if.master          rom_m,
    wb8_if.master          ram_m,
    wb8_if.master          led_m,
    wb8_if.master          tmr_m,
    wb8_if.master          rng_m
);

    logic rom_sel;
    logic ram_sel;
    logic led_sel;
    logic tmr_sel;
    logic rng_sel;

    // reserved and unused ranges fall through to RAM
    always_comb begin
        rom_sel = 1'b0;
        ram_sel = 1'b0;
        led_sel = 1'b0;
        tmr_sel = 1'b0;
        rng_sel = 1'b0;
        if (bus_adr_i[31:11] == ROM_PREFIX) begin
            rom_sel = 1'b1;
        end else begin
            case (bus_adr_i[31:8])
                TIMER_PAGE: tmr_sel = 1'b1;
                PRNG_PAGE:  rng_sel = 1'b1;
                LED_PAGE:   led_sel = 1'b1;
                default:    ram_sel = 1'b1;
            endcase
        end
    end

    // strobe only to the selected slave
    assign rom_m.stb = bus_stb_i & rom_sel;
    assign ram_m.stb = bus_stb_i & ram_sel;
    assign led_m.stb = bus_stb_i & led_sel;
    assign tmr_m.stb = bus_stb_i & tmr_sel;
    assign rng_m.stb = bus_stb_i & rng_sel;

    // address, data and direction go to everyone
    assign rom_m.adr   = bus_adr_i;
    assign ram_m.adr   = bus_adr_i;
    assign led_m.adr   = bus_adr_i;
    assign tmr_m.adr   = bus_adr_i;
    assign rng_m.adr   = bus_adr_i;
    assign rom_m.dat_w = bus_dat_i;
    assign ram_m.dat_w = bus_dat_i;
    assign led_m.dat_w = bus_dat_i;
    assign tmr_m.dat_w = bus_dat_i;
    assign rng_m.dat_w = bus_dat_i;
    assign rom_m.we    = bus_we_i;
    assign ram_m.we    = bus_we_i;
    assign led_m.we    = bus_we_i;
    assign tmr_m.we    = bus_we_i;
    assign rng_m.we    = bus_we_i;

    // return path, master holds the address until ack so the select is stable
    always_comb begin
        if (rom_sel) begin
            bus_dat_o = rom_m.dat_r;
            bus_ack_o = rom_m.ack;
        end else if (tmr_sel) begin
            bus_dat_o = tmr_m.dat_r;
            bus_ack_o = tmr_m.ack;
        end else if (rng_sel) begin
            bus_dat_o = rng_m.dat_r;
            bus_ack_o = rng_m.ack;
        end else if (led_sel) begin
            bus_dat_o = led_m.dat_r;
            bus_ack_o = led_m.ack;
        end else begin
            bus_dat_o = ram_m.dat_r;
            bus_ack_o = ram_m.ack;
        end
    end

endmodule

`default_nettype wire

// ==== source/led_port.sv ====
`timescale 1ns/1ns
`default_nettype none

module led_port
    import soc_pkg::*;
(
    input wire logic clk,
    input wire logic arst_n_i,
    wb8_if.slave     bus,
    output bus_data_t leds_o
);

    bus_data_t leds_q;
    logic      access;

    assign access = bus.stb & ~bus.ack;
    assign leds_o = leds_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bus.ack <= 1'b0;
            leds_q  <= '0;
        end else begin
            bus.ack <= access;
            if (access && bus.we) begin
                // action picked by the low two address bits
                case (bus.adr[1:0])
                    LED_VALUE:  leds_q <= bus.dat_w;
                    LED_SET:    leds_q <= leds_q | bus.dat_w;
                    LED_CLEAR:  leds_q <= leds_q & ~bus.dat_w;
                    LED_TOGGLE: leds_q <= leds_q ^ bus.dat_w;
                    default:    leds_q <= leds_q;
                endcase
            end
        end
    end

    // every offset reads back the register
    always_ff @(posedge clk) begin
        if (access) begin
            bus.dat_r <= leds_q;
        end
    end

endmodule

`default_nettype wire

// ==== source/prng_lfsr.sv ====
`timescale 1ns/1ns
`default_nettype none

module prng_lfsr
    import soc_pkg::*;
(
    input wire logic clk,
    input wire logic arst_n_i,
    wb8_if.slave     bus
);

    lfsr_state_t state_q;
    lfsr_state_t step_val;
    lfsr_state_t seed_val;
    logic        access;

    assign access = bus.stb & ~bus.ack;

    // galois step, shift right and fold taps in on a one shifted out
    assign step_val = (state_q >> 1) ^ (state_q[0] ? LFSR_TAPS : '0);

    always_comb begin
        if (bus.adr[0] == PRNG_HI) begin
            seed_val = {bus.dat_w, state_q[7:0]};
        end else begin
            seed_val = {state_q[15:8], bus.dat_w};
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bus.ack <= 1'b0;
            state_q <= LFSR_DEFAULT_SEED;
        end else begin
            bus.ack <= access;
            if (access && bus.we) begin
                // all-zero state would lock up
                state_q <= (seed_val == '0) ? LFSR_DEFAULT_SEED : seed_val;
            end else if (access && bus.adr[0] == PRNG_LO) begin
                state_q <= step_val;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            bus.dat_r <= (bus.adr[0] == PRNG_HI) ? state_q[15:8] : state_q[7:0];
        end
    end

endmodule

`default_nettype wire

// ==== source/soc_bus_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module soc_bus_top
    import soc_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      arst_n_i,
    input  wire logic      bus_stb_i,
    input  wire logic      bus_we_i,
    input  wire bus_addr_t bus_adr_i,
    input  wire bus_data_t bus_dat_i,
    output bus_data_t      bus_dat_o,
    output logic           bus_ack_o,
    output bus_data_t      leds_o,
    output logic           timer_irq_o
);

    // one bus per slave
    wb8_if rom_bus ();
    wb8_if ram_bus ();
    wb8_if led_bus ();
    wb8_if tmr_bus ();
    wb8_if rng_bus ();

    bus_decoder u_decoder (
        .bus_stb_i (bus_stb_i),
        .bus_adr_i (bus_adr_i),
        .bus_dat_i (bus_dat_i),
        .bus_we_i  (bus_we_i),
        .bus_dat_o (bus_dat_o),
        .bus_ack_o (bus_ack_o),
        .rom_m     (rom_bus.master),
        .ram_m     (ram_bus.master),
        .led_m     (led_bus.master),
        .tmr_m     (tmr_bus.master),
        .rng_m     (rng_bus.master)
    );

    boot_rom u_rom (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .bus      (rom_bus.slave)
    );

    data_ram u_ram (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .bus      (ram_bus.slave)
    );

    led_port u_leds (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .bus      (led_bus.slave),
        .leds_o   (leds_o)
    );

    interval_timer u_timer (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .bus      (tmr_bus.slave),
        .irq_o    (timer_irq_o)
    );

    prng_lfsr u_prng (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .bus      (rng_bus.slave)
    );

endmodule

`default_nettype wire

// ==== timer/interval_timer.sv ====
`timescale 1ns/1ns
`default_nettype none

module interval_timer
    import soc_pkg::*;
(
    input wire logic clk,
    input wire logic arst_n_i,
    wb8_if.slave     bus,
    output logic     irq_o
);

    timer_count_t reload_q;
    timer_count_t count_q;
    bus_data_t    ctrl_q;
    logic         expired_q;
    logic         access;
    logic         wr_en;
    logic         load;
    logic         clear;
    logic         wrap;

    assign access = bus.stb & ~bus.ack;
    assign wr_en  = access & bus.we;

    // rising enable bit starts a fresh period
    assign load  = wr_en && (bus.adr[2:0] == TMR_CTRL) && bus.dat_w[0] && !ctrl_q[0];
    assign clear = wr_en && (bus.adr[2:0] == TMR_STATUS) && bus.dat_w[0];
    assign wrap  = ctrl_q[0] && !load && (count_q == '0);

    assign irq_o = expired_q & ctrl_q[1];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bus.ack   <= 1'b0;
            reload_q  <= '0;
            ctrl_q    <= '0;
            count_q   <= '0;
            expired_q <= 1'b0;
        end else begin
            bus.ack <= access;
            if (wr_en) begin
                case (bus.adr[2:0])
                    TMR_RELOAD_LO: reload_q[7:0]  <= bus.dat_w;
                    TMR_RELOAD_HI: reload_q[15:8] <= bus.dat_w;
                    TMR_CTRL:      ctrl_q         <= bus.dat_w;
                    default:       ctrl_q         <= ctrl_q;
                endcase
            end
            if (load || wrap) begin
                count_q <= reload_q;
            end else if (ctrl_q[0]) begin
                count_q <= count_q - 1'b1;
            end
            // a new expiry wins over a clear in the same cycle
            if (wrap) begin
                expired_q <= 1'b1;
            end else if (clear) begin
                expired_q <= 1'b0;
            end
        end
    end

    // count registers are a snapshot, writes to them are dropped
    always_ff @(posedge clk) begin
        if (access) begin
            case (bus.adr[2:0])
                TMR_RELOAD_LO: bus.dat_r <= reload_q[7:0];
                TMR_RELOAD_HI: bus.dat_r <= reload_q[15:8];
                TMR_CTRL:      bus.dat_r <= ctrl_q;
                TMR_STATUS:    bus.dat_r <= {7'b0, expired_q};
                TMR_COUNT_LO:  bus.dat_r <= count_q[7:0];
                TMR_COUNT_HI:  bus.dat_r <= count_q[15:8];
                default:       bus.dat_r <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verification/soc_bus_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module soc_bus_properties (
    input wire logic clk,
    input wire logic arst_n_i,
    input wire logic stb_i,
    input wire logic ack_i,
    input wire logic irq_i
);

    // count of failed properties
    int failures = 0;

    // ack answers a strobe seen on the edge before
    ack_follows_stb: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        ack_i |-> $past(stb_i)
    ) else begin
        $error("bus ack without a strobe in the previous cycle");
        failures++;
    end

    ack_single_cycle: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        ack_i |=> !ack_i
    ) else begin
        $error("bus ack high for two cycles in a row");
        failures++;
    end

    // first reset edge only settles the flops
    quiet_in_reset: assert property (
        @(posedge clk)
        (!arst_n_i && $past(!arst_n_i)) |-> (!ack_i && !irq_i)
    ) else begin
        $error("bus ack or timer interrupt active during reset");
        failures++;
    end

endmodule

bind soc_bus_top soc_bus_properties u_props (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .stb_i    (bus_stb_i),
    .ack_i    (bus_ack_o),
    .irq_i    (timer_irq_o)
);

`default_nettype wire

// ==== verification/soc_bus_stimulus.txt ====
# columns: test name, operation, address or count base, data or count, expected (all hex)
# W write, R read, L leds, M random ram, T timer (reload ctrl irq), P prng (seed reads first)
rom_first    R FFFFF000 00 3C
rom_mid      R FFFFF005 00 F5
rom_last     R FFFFF03F 00 57
rom_mirror0  R FFFFF040 00 3C
rom_mirror1  R FFFFF7E9 00 29
rom_mirror2  R FFFFF412 00 D6
rom_write    W FFFFF005 00 00
rom_keep     R FFFFF005 00 F5
ram_low      W 00000123 5A 00
ram_low_rd   R 00000123 00 5A
ram_uart     W FFFFFB10 A5 00
ram_uart_rd  R FFFFFB10 00 A5
ram_spi      W FFFFFC7E 3C 00
ram_spi_rd   R FFFFFC7E 00 3C
ram_rand0    M 00004000 20 00
ram_rand1    M FFFFFB00 10 00
ram_rand2    M FFFFFC00 10 00
led_value    W FFFFFF00 96 00
led_set      W FFFFFF01 41 00
led_chk0     L FFFFFF00 00 D7
led_clear    W FFFFFF02 0F 00
led_toggle   W FFFFFF03 FF 00
led_chk1     L FFFFFF03 00 2F
tmr_irq      T 00000018 03 01
tmr_long     T 00000105 03 01
tmr_noirq    T 00000020 01 00
rng_zero     P 00000000 06 E1
rng_seed     P 00001234 08 34

// ==== verification/soc_bus_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module soc_bus_tb
    import soc_pkg::*;
();

    localparam int        ACK_TIMEOUT = 8;
    localparam bus_addr_t TIMER_BASE  = {TIMER_PAGE, 8'h00};
    localparam bus_addr_t PRNG_BASE   = {PRNG_PAGE, 8'h00};

    logic        clk;
    logic        arst_n_i;
    logic        bus_stb_i;
    logic        bus_we_i;
    bus_addr_t   bus_adr_i;
    bus_data_t   bus_dat_i;
    bus_data_t   bus_dat_o;
    logic        bus_ack_o;
    bus_data_t   leds_o;
    logic        timer_irq_o;

    integer      seed;
    bus_data_t   ram_shadow [0:RAM_BYTES-1];
    bus_data_t   led_shadow;
    lfsr_state_t lfsr_model;

    soc_bus_top UUT (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .bus_stb_i   (bus_stb_i),
        .bus_we_i    (bus_we_i),
        .bus_adr_i   (bus_adr_i),
        .bus_dat_i   (bus_dat_i),
        .bus_dat_o   (bus_dat_o),
        .bus_ack_o   (bus_ack_o),
        .leds_o      (leds_o),
        .timer_irq_o (timer_irq_o)
    );

    always #2 clk = ~clk;

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_data(input string name, input bus_data_t expected,
                              input bus_data_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("** Error %s: data expected %h, actual %h",
                                     name, expected, actual));
        end
    endtask

    task automatic check_leds(input string name, input bus_data_t expected,
                              input bus_data_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("** Error %s: leds expected %h, actual %h",
                                     name, expected, actual));
        end
    endtask

    task automatic check_irq(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            report_failure($sformatf("** Error %s: irq expected %b, actual %b",
                                     name, expected, actual));
        end
    endtask

    // one transfer, strobe held until ack, which must come after one cycle
    task automatic bus_access(input bus_addr_t addr, input logic we,
                              input bus_data_t wdata, output bus_data_t rdata);
        int cycles;
        @(negedge clk);
        bus_adr_i = addr;
        bus_we_i  = we;
        bus_dat_i = wdata;
        bus_stb_i = 1'b1;
        @(negedge clk);
        cycles = 1;
        while (bus_ack_o !== 1'b1 && cycles < ACK_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (bus_ack_o !== 1'b1) begin
            report_failure($sformatf("no ack from address %h within %0d cycles", addr, cycles));
        end else if (cycles != 1) begin
            report_failure($sformatf("ack from address %h came after %0d cycles, not one",
                                     addr, cycles));
        end
        rdata     = bus_dat_o;
        bus_stb_i = 1'b0;
        bus_we_i  = 1'b0;
    endtask

    task automatic bus_write(input bus_addr_t addr, input bus_data_t data);
        bus_data_t ignored;
        bus_access(addr, 1'b1, data, ignored);
    endtask

    task automatic bus_read(input bus_addr_t addr, output bus_data_t data);
        bus_access(addr, 1'b0, 8'h00, data);
    endtask

    // anything outside the ROM window and the three pages lands in RAM
    function automatic logic is_ram_addr(input bus_addr_t addr);
        return (addr[31:11] != ROM_PREFIX) && (addr[31:8] != TIMER_PAGE)
            && (addr[31:8] != PRNG_PAGE) && (addr[31:8] != LED_PAGE);
    endfunction

    function automatic bus_data_t led_apply(input bus_data_t cur, input logic [1:0] offset,
                                            input bus_data_t data);
        bus_data_t result;
        case (offset)
            LED_VALUE: result = data;
            LED_SET:   result = cur | data;
            LED_CLEAR: result = cur & ~data;
            default:   result = cur ^ data;
        endcase
        return result;
    endfunction

    function automatic lfsr_state_t lfsr_next(input lfsr_state_t s);
        lfsr_state_t result;
        result = s >> 1;
        if (s[0]) begin
            result = result ^ LFSR_TAPS;
        end
        return result;
    endfunction

    // zero state gets replaced by the default seed
    function automatic lfsr_state_t lfsr_seeded(input lfsr_state_t s);
        return (s == 16'h0000) ? LFSR_DEFAULT_SEED : s;
    endfunction

    // write and keep the shadow models in step
    task automatic write_and_track(input string name, input bus_addr_t addr,
                                   input bus_data_t data);
        bus_write(addr, data);
        if (is_ram_addr(addr)) begin
            ram_shadow[addr[RAM_ADDR_BITS-1:0]] = data;
        end else if (addr[31:8] == LED_PAGE) begin
            led_shadow = led_apply(led_shadow, addr[1:0], data);
            check_leds(name, led_shadow, leds_o);
        end else if (addr[31:8] == PRNG_PAGE) begin
            if (addr[0]) begin
                lfsr_model = lfsr_seeded({data, lfsr_model[7:0]});
            end else begin
                lfsr_model = lfsr_seeded({lfsr_model[15:8], data});
            end
        end
    endtask

    task automatic random_ram(input string name, input bus_addr_t base, input int count);
        bus_addr_t addrs [$];
        bus_addr_t addr;
        logic [31:0] rnd;
        bus_data_t rd;
        int i;
        for (i = 0; i < count; i++) begin
            rnd  = $random(seed);
            addr = {base[31:8], rnd[7:0]};
            addrs.push_back(addr);
            write_and_track(name, addr, rnd[15:8]);
        end
        for (i = 0; i < addrs.size(); i++) begin
            bus_read(addrs[i], rd);
            check_data(name, ram_shadow[addrs[i][RAM_ADDR_BITS-1:0]], rd);
        end
    endtask

    task automatic run_timer(input string name, input timer_count_t reload,
                             input bus_data_t ctrl, input logic irq_exp);
        bus_data_t status;
        int limit;
        int cycles;
        limit = 2 * reload + 16;
        bus_write(TIMER_BASE | TMR_CTRL, 8'h00);
        bus_write(TIMER_BASE | TMR_STATUS, 8'h01);
        bus_write(TIMER_BASE | TMR_RELOAD_LO, reload[7:0]);
        bus_write(TIMER_BASE | TMR_RELOAD_HI, reload[15:8]);
        bus_write(TIMER_BASE | TMR_CTRL, ctrl);
        cycles = 0;
        status = 8'h00;
        if (irq_exp) begin
            while (timer_irq_o !== 1'b1 && cycles < limit) begin
                @(negedge clk);
                cycles++;
            end
            if (timer_irq_o !== 1'b1) begin
                report_failure($sformatf("%s: no timer interrupt within %0d cycles", name, limit));
            end
            bus_read(TIMER_BASE | TMR_STATUS, status);
        end else begin
            // no interrupt expected, so poll the flag instead
            while (status[0] !== 1'b1 && cycles < limit) begin
                bus_read(TIMER_BASE | TMR_STATUS, status);
                check_irq(name, 1'b0, timer_irq_o);
                cycles += 2;
            end
            if (status[0] !== 1'b1) begin
                report_failure($sformatf("%s: expiry flag not set within %0d cycles", name, limit));
            end
        end
        check_irq(name, irq_exp, timer_irq_o);
        check_data(name, 8'h01, status);
        bus_write(TIMER_BASE | TMR_STATUS, 8'h01);
        check_irq(name, 1'b0, timer_irq_o);
        bus_write(TIMER_BASE | TMR_CTRL, 8'h00);
        bus_write(TIMER_BASE | TMR_STATUS, 8'h01);
    endtask

    task automatic check_prng(input string name, input lfsr_state_t seed_val,
                              input int reads, input bus_data_t first_exp);
        bus_data_t rd;
        int i;
        write_and_track(name, PRNG_BASE | 32'h1, seed_val[15:8]);
        write_and_track(name, PRNG_BASE, seed_val[7:0]);
        for (i = 0; i < reads; i++) begin
            bus_read(PRNG_BASE, rd);
            if (i == 0) begin
                check_data(name, first_exp, rd);
            end
            check_data(name, lfsr_model[7:0], rd);
            lfsr_model = lfsr_next(lfsr_model);
        end
        // high byte read leaves the state alone
        bus_read(PRNG_BASE | 32'h1, rd);
        check_data(name, lfsr_model[15:8], rd);
    endtask

    initial begin
        int fd;
        int fields;
        logic [8*128-1:0] line_buf;
        string test_name;
        string op;
        logic [31:0] addr_val;
        logic [31:0] data_val;
        logic [31:0] exp_val;
        bus_data_t rd;
        clk        = 1'b0;
        arst_n_i   = 1'b0;
        bus_stb_i  = 1'b0;
        bus_we_i   = 1'b0;
        bus_adr_i  = '0;
        bus_dat_i  = '0;
        seed       = 84793;
        led_shadow = '0;
        lfsr_model = LFSR_DEFAULT_SEED;
        repeat (4) @(negedge clk);
        arst_n_i = 1'b1;
        check_leds("reset", 8'h00, leds_o);
        check_irq("reset", 1'b0, timer_irq_o);

        fd = $fopen("verification/soc_bus_stimulus.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open verification/soc_bus_stimulus.txt");
        end
        while ($fgets(line_buf, fd) != 0) begin
            fields = $sscanf(line_buf, "%s %s %h %h %h",
                             test_name, op, addr_val, data_val, exp_val);
            if (fields > 0 && test_name.getc(0) != "#") begin
                if (fields != 5) begin
                    report_failure($sformatf("badly formed stimulus line for %s", test_name));
                end
                case (op)
                    "W": write_and_track(test_name, addr_val, data_val[7:0]);
                    "R": begin
                        bus_read(addr_val, rd);
                        check_data(test_name, exp_val[7:0], rd);
                    end
                    "L": begin
                        check_leds(test_name, exp_val[7:0], leds_o);
                        bus_read(addr_val, rd);
                        check_data(test_name, led_shadow, rd);
                    end
                    "M": random_ram(test_name, addr_val, data_val);
                    "T": run_timer(test_name, addr_val[15:0], data_val[7:0], exp_val[0]);
                    "P": check_prng(test_name, addr_val[15:0], data_val, exp_val[7:0]);
                    default: begin
                        report_failure($sformatf("unknown operation %s in %s", op, test_name));
                    end
                endcase
            end
        end
        $fclose(fd);
        if (UUT.u_props.failures != 0) begin
            report_failure($sformatf("%0d bus property checks failed",
                                     UUT.u_props.failures));
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

`default_nettype wire
